/* files.f */
+incdir+logic
logic/bexkat_pkg.sv
logic/cpu_ctrl_if.sv
logic/cpu_sequencer.sv
logic/settle_timer.sv
logic/alu.sv
logic/register_file.sv
logic/bus_unit.sv
logic/bexkat_top.sv
verif/tb_avalon_mem.sv
verif/tb_bexkat.sv

/* Bender.yml */
package:
  name: bexkat1

sources:
  - include_dirs:
      - logic
    files:
      - logic/bexkat_pkg.sv
      - logic/cpu_ctrl_if.sv
      - logic/cpu_sequencer.sv
      - logic/settle_timer.sv
      - logic/alu.sv
      - logic/register_file.sv
      - logic/bus_unit.sv
      - logic/bexkat_top.sv
  - target: simulation
    files:
      - verif/tb_avalon_mem.sv
      - verif/tb_bexkat.sv

/* verif/tb_bexkat.sv */
`timescale 1ns/1ps

module tb_bexkat;

  logic csi_clk;
  logic rsi_reset_n;
  logic [31:0] address, readdata, writedata, store_addr, store_data;
  logic read, write, waitrequest, store_seen;
  logic [3:0] byteenable;

  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  string exp_name [$];
  int errors;
  int timeouts;
  bit got;
  bit stop;

  bexkat_top uut (.csi_clk, .rsi_reset_n, .avm_m0_waitrequest(waitrequest),
    .avm_m0_address(address), .avm_m0_read(read), .avm_m0_readdata(readdata),
    .avm_m0_writedata(writedata), .avm_m0_write(write), .avm_m0_byteenable(byteenable));

  tb_avalon_mem mem_model (.csi_clk, .rsi_reset_n, .address, .read, .write, .writedata,
    .readdata, .waitrequest, .store_seen, .store_addr, .store_data);

  initial begin
    csi_clk = 1'b0;
    forever #4 csi_clk = ~csi_clk;
  end

  function automatic logic [31:0] reg_instr(input logic [7:0] op, input logic [4:0] ra,
                                            input logic [4:0] rb, input logic [4:0] rc);
    return {3'd0, op, ra, rb, rc, 6'd0};
  endfunction

  function automatic logic [31:0] imm_instr(input logic [7:0] op, input logic [4:0] ra,
                                            input logic [15:0] imm);
    return {3'd2, op, ra, imm};
  endfunction

  // effective offset of a regind access is sign-extended {rb, off}
  function automatic logic [31:0] mem_instr(input logic [7:0] op, input logic [4:0] ra,
                                            input logic [4:0] rb, input logic [10:0] off);
    return {3'd1, op, ra, rb, off};
  endfunction

  task automatic store_and_expect(input logic [4:0] ra, input logic [10:0] addr,
                                  input logic [31:0] data, input string name);
    prog.push_back(mem_instr(8'h00, ra, 5'd0, addr));  // r0 stays zero as base
    exp_addr.push_back({21'd0, addr});
    exp_data.push_back(data);
    exp_name.push_back(name);
  endtask

  // cmp and a branch over a bad marker store, then the good marker store
  task automatic branch_case(input logic [7:0] br, input logic [4:0] a, input logic [4:0] b,
                             input bit taken, input logic [10:0] addr, input string name);
    prog.push_back(reg_instr(8'h02, a, b, 5'd0));
    prog.push_back(imm_instr(br, 5'd0, 16'd4));
    if (taken)
      prog.push_back(mem_instr(8'h00, 5'd14, 5'd0, addr));
    store_and_expect(5'd13, addr, 32'h0000_600D, name);
  endtask

  task automatic wait_level(input logic level, input string what);
    got = 1'b0;
    for (int c = 0; c < 500 && !got; c++) begin
      @(posedge csi_clk);
      if (read === level)
        got = 1'b1;
    end
    if (!got) begin
      $display("timeout waiting for %s", what);
      timeouts++;
      stop = 1'b1;
    end
  endtask

  initial begin
    rsi_reset_n = 1'b0;
    errors = 0;
    timeouts = 0;
    stop = 1'b0;
    prog.push_back(imm_instr(8'h0c, 5'd2, 16'hFFFE));   // ldis
    prog.push_back(imm_instr(8'h0d, 5'd3, 16'hFFFE));   // ldiu
    prog.push_back(imm_instr(8'h0d, 5'd4, 16'h1234));
    prog.push_back(imm_instr(8'h0d, 5'd5, 16'h0F0F));
    prog.push_back(imm_instr(8'h0d, 5'd6, 16'h0004));
    prog.push_back(imm_instr(8'h0d, 5'd13, 16'h600D));  // good marker
    prog.push_back(imm_instr(8'h0d, 5'd14, 16'h0BAD));  // bad marker
    prog.push_back(imm_instr(8'h0d, 5'd1, 16'h0100));   // ld.l base
    store_and_expect(5'd2, 11'h400, 32'hFFFF_FFFE, "ldis");
    store_and_expect(5'd3, 11'h404, 32'h0000_FFFE, "ldiu");
    prog.push_back(reg_instr(8'h20, 5'd7, 5'd4, 5'd5));
    store_and_expect(5'd7, 11'h408, 32'h0000_0204, "and");
    prog.push_back(reg_instr(8'h21, 5'd7, 5'd4, 5'd5));
    store_and_expect(5'd7, 11'h40C, 32'h0000_1F3F, "or");
    prog.push_back(reg_instr(8'h22, 5'd7, 5'd4, 5'd5));
    store_and_expect(5'd7, 11'h410, 32'h0000_2143, "add");
    prog.push_back(reg_instr(8'h23, 5'd7, 5'd4, 5'd5));
    store_and_expect(5'd7, 11'h414, 32'h0000_0325, "sub");
    prog.push_back(reg_instr(8'h24, 5'd7, 5'd4, 5'd5));
    store_and_expect(5'd7, 11'h418, 32'h0000_1D3B, "xor");
    prog.push_back(reg_instr(8'h25, 5'd7, 5'd4, 5'd6));
    store_and_expect(5'd7, 11'h41C, 32'h0001_2340, "shl");
    prog.push_back(reg_instr(8'h26, 5'd7, 5'd4, 5'd6));
    store_and_expect(5'd7, 11'h420, 32'h0000_0123, "shr");
    prog.push_back(reg_instr(8'h07, 5'd8, 5'd4, 5'd0));
    prog.push_back(reg_instr(8'h03, 5'd8, 5'd0, 5'd0));
    store_and_expect(5'd8, 11'h424, 32'h1235, "inc");
    prog.push_back(reg_instr(8'h07, 5'd9, 5'd5, 5'd0));
    prog.push_back(reg_instr(8'h04, 5'd9, 5'd0, 5'd0));
    store_and_expect(5'd9, 11'h428, 32'h0F0E, "dec");
    prog.push_back(reg_instr(8'h07, 5'd10, 5'd4, 5'd0));
    store_and_expect(5'd10, 11'h42C, 32'h1234, "mov");
    prog.push_back(reg_instr(8'h08, 5'd11, 5'd4, 5'd0));
    store_and_expect(5'd11, 11'h430, 32'hFFFF_EDCB, "com");
    prog.push_back(reg_instr(8'h09, 5'd12, 5'd4, 5'd0));
    store_and_expect(5'd12, 11'h434, 32'hFFFF_EDCC, "neg");
    prog.push_back(reg_instr(8'h00, 5'd0, 5'd0, 5'd0));  // nop
    branch_case(8'h01, 5'd4, 5'd10, 1'b1, 11'h440, "beq_equal");
    branch_case(8'h02, 5'd4, 5'd5, 1'b1, 11'h444, "bne_unequal");
    branch_case(8'h01, 5'd4, 5'd5, 1'b0, 11'h448, "beq_unequal");
    branch_case(8'h07, 5'd2, 5'd4, 1'b1, 11'h44C, "blt_negative");
    branch_case(8'h09, 5'd2, 5'd4, 1'b0, 11'h450, "bltu_large");
    branch_case(8'h09, 5'd4, 5'd2, 1'b1, 11'h454, "bltu_small");
    branch_case(8'h07, 5'd4, 5'd2, 1'b0, 11'h458, "blt_positive");
    branch_case(8'h00, 5'd4, 5'd2, 1'b1, 11'h45C, "bra");
    prog.push_back(mem_instr(8'h01, 5'd15, 5'd1, 11'h200));  // 0x100 + 0xA00
    store_and_expect(5'd15, 11'h460, 32'hCAFE_F00D, "ld_l");
    prog.push_back(reg_instr(8'hFF, 5'd0, 5'd0, 5'd0));  // illegal opcode
    #1;
    foreach (prog[i])
      mem_model.mem[i] = prog[i];
    mem_model.mem[32'hB00 >> 2] = 32'hCAFE_F00D;
    repeat (3) @(posedge csi_clk);
    rsi_reset_n <= 1'b1;

    foreach (exp_addr[k]) begin
      if (!stop) begin
        got = 1'b0;
        for (int c = 0; c < 2000 && !got; c++) begin
          @(posedge csi_clk);
          if (write && byteenable !== 4'hF) begin
            $display("FAIL %s byteenable: expected %h, actual %h", exp_name[k], 4'hF,
                     byteenable);
            errors++;
          end
          if (store_seen)
            got = 1'b1;
        end
        if (!got) begin
          $display("timeout waiting for the store of %s", exp_name[k]);
          timeouts++;
          stop = 1'b1;
        end else begin
          if (store_addr !== exp_addr[k]) begin
            $display("FAIL %s address: expected %h, actual %h", exp_name[k], exp_addr[k],
                     store_addr);
            errors++;
          end
          if (store_data !== exp_data[k]) begin
            $display("FAIL %s data: expected %h, actual %h", exp_name[k], exp_data[k],
                     store_data);
            errors++;
          end
        end
      end
    end

    // fetch of the illegal opcode and then silence
    if (!stop)
      wait_level(1'b1, "the fetch of the illegal opcode");
    if (!stop)
      wait_level(1'b0, "the end of the last fetch");
    if (!stop) begin
      for (int c = 0; c < 50; c++) begin
        @(posedge csi_clk);
        if (read || write) begin
          $display("bus still active %0d cycles into the fault window", c);
          errors++;
        end
      end
    end

    $display("summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verif/tb_avalon_mem.sv */
`timescale 1ns/1ps

module tb_avalon_mem (
  input  logic        csi_clk,
  input  logic        rsi_reset_n,
  input  logic [31:0] address,
  input  logic        read,
  input  logic        write,
  input  logic [31:0] writedata,
  output logic [31:0] readdata,
  output logic        waitrequest,
  output logic        store_seen,
  output logic [31:0] store_addr,
  output logic [31:0] store_data
);

  logic [31:0] mem [1024];  // 4 KB indexed by address[11:2]
  logic [31:0] lfsr;
  logic [1:0] stall;
  logic [1:0] nxt;

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  initial begin
    lfsr = 32'h6598_9203;
    waitrequest = 1'b1;  // idle with waitrequest up
    readdata = '0;
    store_seen = 1'b0;
    store_addr = '0;
    store_data = '0;
    stall = 2'd0;
    nxt = 2'd0;
    for (int i = 0; i < 1024; i++)
      mem[i] = {16'hFA11, 6'd0, i[9:0]};  // mode 7 faults if fetched
  end

  always @(posedge csi_clk) begin
    store_seen <= 1'b0;
    if (!rsi_reset_n) begin
      waitrequest <= 1'b1;
    end else if ((read || write) && waitrequest) begin
      if (stall == 2'd0) begin
        waitrequest <= 1'b0;
        readdata <= mem[address[11:2]];
      end else begin
        stall <= stall - 2'd1;  // extra random wait
      end
    end else if ((read || write) && !waitrequest) begin
      waitrequest <= 1'b1;  // access completes on this edge
      if (write) begin
        mem[address[11:2]] <= writedata;
        store_seen <= 1'b1;
        store_addr <= address;
        store_data <= writedata;
      end
      for (int b = 0; b < 2; b++) begin
        lfsr = lfsr_next(lfsr);
        nxt = {nxt[0], lfsr[0]};
      end
      stall <= nxt;
    end
  end

endmodule

/* logic/bexkat_top.sv */
`timescale 1ns/1ps
`include "bexkat_config.svh"

module bexkat_top (
  input  logic                        csi_clk,
  input  logic                        rsi_reset_n,
  input  logic                        avm_m0_waitrequest,
  output logic [`BEXKAT_DATA_W-1:0]   avm_m0_address,
  output logic                        avm_m0_read,
  input  logic [`BEXKAT_DATA_W-1:0]   avm_m0_readdata,
  output logic [`BEXKAT_DATA_W-1:0]   avm_m0_writedata,
  output logic                        avm_m0_write,
  output logic [`BEXKAT_DATA_W/8-1:0] avm_m0_byteenable
);
  import bexkat_pkg::*;

  cpu_ctrl_if ctrl ();

  ir_fields_t ir;
  ccr_t ccr, alu_flags;
  logic settle_start, settle_done;
  logic [`BEXKAT_DATA_W-1:0] rd_data1, rd_data2, alu_in2, alu_result, wr_data, mar, mdr;

  always_comb begin
    case (ctrl.alu_src)
      src_imm: alu_in2 = mar;  // sign-extended offset
      src_one: alu_in2 = `BEXKAT_DATA_W'(1);
      default: alu_in2 = rd_data2;
    endcase
    case (ctrl.wr_sel)
      wr_rd1:  wr_data = rd_data1;
      wr_com:  wr_data = ~rd_data1;
      wr_neg:  wr_data = -rd_data1;
      wr_mar:  wr_data = mar;
      wr_mdr:  wr_data = mdr;
      default: wr_data = alu_result;
    endcase
  end

  cpu_sequencer u_seq (.csi_clk, .rsi_reset_n, .ctrl(ctrl.seq), .ir, .ccr,
    .waitrequest(avm_m0_waitrequest), .settle_start, .settle_done);

  settle_timer u_settle (.csi_clk, .rsi_reset_n, .start(settle_start), .busy(),
    .done(settle_done));

  alu u_alu (.in1(rd_data1), .in2(alu_in2), .func(ctrl.alu_func), .result(alu_result),
    .flags(alu_flags));

  register_file u_regs (.csi_clk, .rsi_reset_n, .ctrl(ctrl.regs), .wr_data, .rd_data1,
    .rd_data2);

  bus_unit u_bus (.csi_clk, .rsi_reset_n, .ctrl(ctrl.bus), .alu_result, .alu_flags,
    .reg_data(rd_data2), .ir, .ccr, .mar, .mdr, .address(avm_m0_address),
    .read(avm_m0_read), .write(avm_m0_write), .writedata(avm_m0_writedata),
    .byteenable(avm_m0_byteenable), .readdata(avm_m0_readdata));

endmodule

/* logic/bus_unit.sv */
`timescale 1ns/1ps
`include "bexkat_config.svh"

module bus_unit (
  input  logic                          csi_clk,
  input  logic                          rsi_reset_n,
  cpu_ctrl_if.bus                       ctrl,
  input  logic [`BEXKAT_DATA_W-1:0]     alu_result,
  input  bexkat_pkg::ccr_t              alu_flags,
  input  logic [`BEXKAT_DATA_W-1:0]     reg_data,
  output bexkat_pkg::ir_fields_t        ir,
  output bexkat_pkg::ccr_t              ccr,
  output logic [`BEXKAT_DATA_W-1:0]     mar,
  output logic [`BEXKAT_DATA_W-1:0]     mdr,
  output logic [`BEXKAT_DATA_W-1:0]     address,
  output logic                          read,
  output logic                          write,
  output logic [`BEXKAT_DATA_W-1:0]     writedata,
  output logic [`BEXKAT_DATA_W/8-1:0]   byteenable,
  input  logic [`BEXKAT_DATA_W-1:0]     readdata
);
  import bexkat_pkg::*;

  logic [`BEXKAT_DATA_W-1:0] pc;
  imm16_t imm;

  assign imm = readdata[15:0];

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      pc <= `BEXKAT_RESET_PC;
      ir <= '0;
      ccr <= '0;
      read <= 1'b0;
      write <= 1'b0;
    end else begin
      if (ctrl.pc_inc)
        pc <= pc + `BEXKAT_DATA_W'(4);
      else if (ctrl.pc_branch)
        pc <= pc + mar;  // pc already advanced
      if (ctrl.load_ir)
        ir <= ir_fields_t'(readdata);
      if (ctrl.ccr_load)
        ccr <= alu_flags;
      read <= ctrl.bus_rd_start;
      write <= ctrl.bus_wr_start;
    end
  end

  always_ff @(posedge csi_clk) begin
    if (ctrl.load_ir) begin
      mar <= {{(`BEXKAT_DATA_W-16){imm[15]}}, imm};  // ldis and branch offset
      mdr <= {{(`BEXKAT_DATA_W-16){1'b0}}, imm};      // ldiu
    end else begin
      if (ctrl.mar_load_alu)
        mar <= alu_result;
      if (ctrl.mdr_load_reg)
        mdr <= reg_data;
      else if (ctrl.mdr_load_bus)
        mdr <= readdata;
    end
  end

  assign address = (ctrl.addr_sel == addr_mar) ? mar : pc;
  assign writedata = mdr;  // big-endian with no swap
  assign byteenable = '1;

  a_addr_stable: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    read |=> !read || $stable(address)) else $error("address moved during read");

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps
`include "bexkat_config.svh"

module register_file (
  input  logic                      csi_clk,
  input  logic                      rsi_reset_n,
  cpu_ctrl_if.regs                  ctrl,
  input  logic [`BEXKAT_DATA_W-1:0] wr_data,
  output logic [`BEXKAT_DATA_W-1:0] rd_data1,
  output logic [`BEXKAT_DATA_W-1:0] rd_data2
);

  logic [`BEXKAT_DATA_W-1:0] regs [`BEXKAT_REG_N];

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      for (int i = 0; i < `BEXKAT_REG_N; i++)
        regs[i] <= '0;
    end else if (ctrl.wr_en) begin
      regs[ctrl.wr_addr] <= wr_data;  // r0 is writable
    end
  end

  // async read ports
  assign rd_data1 = regs[ctrl.rd_addr1];
  assign rd_data2 = regs[ctrl.rd_addr2];

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps
`include "bexkat_config.svh"

module alu (
  input  logic [`BEXKAT_DATA_W-1:0] in1,
  input  logic [`BEXKAT_DATA_W-1:0] in2,
  input  bexkat_pkg::alu_func_t     func,
  output logic [`BEXKAT_DATA_W-1:0] result,
  output bexkat_pkg::ccr_t          flags
);
  import bexkat_pkg::*;

  localparam int MSB = `BEXKAT_DATA_W - 1;

  logic [`BEXKAT_DATA_W:0] wide;  // extra bit is carry or borrow

  always_comb begin
    wide = '0;
    case (func)
      alu_and: wide[MSB:0] = in1 & in2;
      alu_or:  wide[MSB:0] = in1 | in2;
      alu_add: wide = {1'b0, in1} + {1'b0, in2};
      alu_sub: wide = {1'b0, in1} - {1'b0, in2};
      alu_xor: wide[MSB:0] = in1 ^ in2;
      alu_shl: wide[MSB:0] = in1 << in2[$clog2(`BEXKAT_DATA_W)-1:0];
      alu_shr: wide[MSB:0] = in1 >> in2[$clog2(`BEXKAT_DATA_W)-1:0];
      default: wide = '0;
    endcase
  end

  assign result = wide[MSB:0];

  always_comb begin
    flags.carry = wide[`BEXKAT_DATA_W];
    flags.negative = result[MSB];
    flags.zero = (result == '0);
    case (func)
      alu_add: flags.overflow = (in1[MSB] == in2[MSB]) && (result[MSB] != in1[MSB]);
      alu_sub: flags.overflow = (in1[MSB] != in2[MSB]) && (result[MSB] != in1[MSB]);
      default: flags.overflow = 1'b0;
    endcase
  end

endmodule

/* logic/settle_timer.sv */
`timescale 1ns/1ps
`include "bexkat_config.svh"

module settle_timer (
  input  logic csi_clk,
  input  logic rsi_reset_n,
  input  logic start,
  output logic busy,
  output logic done
);

  localparam int CNT_W = $clog2(`BEXKAT_CMP_SETTLE + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n)
      count <= '0;
    else if (start)
      count <= CNT_W'(`BEXKAT_CMP_SETTLE);
    else if (busy)
      count <= count - 1'b1;
  end

  assign busy = (count != '0);
  assign done = (count == CNT_W'(1));  // last settle cycle

  a_no_restart: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    start |-> !busy) else $error("settle timer restarted while busy");

endmodule

/* logic/cpu_sequencer.sv */
`timescale 1ns/1ps

module cpu_sequencer (
  input  logic                   csi_clk,
  input  logic                   rsi_reset_n,
  cpu_ctrl_if.seq                ctrl,
  input  bexkat_pkg::ir_fields_t ir,
  input  bexkat_pkg::ccr_t       ccr,
  input  logic                   waitrequest,
  output logic                   settle_start,
  input  logic                   settle_done
);
  import bexkat_pkg::*;

  cpu_state_t state, state_next;
  cpu_state_t retstate, retstate_next;   // eval after a fetch, load_done after ld.l
  logic cmp_wait, cmp_wait_next;
  logic take_branch;

  always_ff @(posedge csi_clk or negedge rsi_reset_n) begin
    if (!rsi_reset_n) begin
      state <= st_fetch;
      retstate <= st_eval;
      cmp_wait <= 1'b0;
    end else begin
      state <= state_next;
      retstate <= retstate_next;
      cmp_wait <= cmp_wait_next;
    end
  end

  always_comb begin
    case (ir.op)
      8'h01: take_branch = ccr.zero;                   // beq
      8'h02: take_branch = !ccr.zero;                  // bne
      8'h07: take_branch = ccr.negative ^ ccr.overflow; // blt
      8'h09: take_branch = ccr.carry;                  // bltu
      default: take_branch = 1'b1;                     // bra
    endcase
  end

  always_comb begin
    state_next = state;
    retstate_next = retstate;
    cmp_wait_next = cmp_wait;
    settle_start = 1'b0;
    ctrl.alu_func = alu_add;
    ctrl.alu_src = src_reg;
    ctrl.rd_addr1 = ir.ra;
    ctrl.rd_addr2 = ir.rb;
    ctrl.wr_en = 1'b0;
    ctrl.wr_addr = ir.ra;
    ctrl.wr_sel = wr_alu;
    ctrl.load_ir = 1'b0;
    ctrl.addr_sel = addr_pc;
    ctrl.pc_inc = 1'b0;
    ctrl.pc_branch = 1'b0;
    ctrl.mar_load_alu = 1'b0;
    ctrl.mdr_load_reg = 1'b0;
    ctrl.mdr_load_bus = 1'b0;
    ctrl.ccr_load = 1'b0;
    ctrl.bus_rd_start = 1'b0;
    ctrl.bus_wr_start = 1'b0;

    case (state)
      st_fetch: begin
        ctrl.bus_rd_start = 1'b1;
        retstate_next = st_eval;
        state_next = st_memload;
      end
      st_memload: begin
        ctrl.addr_sel = (retstate == st_load_done) ? addr_mar : addr_pc;
        if (waitrequest) begin
          ctrl.bus_rd_start = 1'b1;  // keep strobe up
        end else begin
          state_next = retstate;
          ctrl.load_ir = (retstate == st_eval);
          ctrl.pc_inc = (retstate == st_eval);
          ctrl.mdr_load_bus = (retstate != st_eval);
        end
      end
      st_memsave: begin
        ctrl.addr_sel = addr_mar;
        if (waitrequest)
          ctrl.bus_wr_start = 1'b1;
        else
          state_next = st_store_done;
      end
      st_load_done: begin
        ctrl.wr_en = 1'b1;
        ctrl.wr_sel = wr_mdr;
        state_next = st_fetch;
      end
      st_store_done: state_next = st_fetch;
      st_eval: begin
        state_next = st_fetch;
        case (ir.mode)
          mode_reg: begin
            case (ir.op)
              8'h00: ;  // nop
              8'h02: begin  // cmp loads flags after the settle delay
                ctrl.alu_func = alu_sub;
                state_next = st_eval;
                if (!cmp_wait) begin
                  settle_start = 1'b1;
                  cmp_wait_next = 1'b1;
                end else if (settle_done) begin
                  ctrl.ccr_load = 1'b1;
                  cmp_wait_next = 1'b0;
                  state_next = st_fetch;
                end
              end
              8'h03, 8'h04: begin  // inc, dec
                ctrl.alu_func = ir.op[2] ? alu_sub : alu_add;
                ctrl.alu_src = src_one;
                ctrl.wr_en = 1'b1;
              end
              8'h07, 8'h08, 8'h09: begin  // mov, com, neg of rb
                ctrl.rd_addr1 = ir.rb;
                ctrl.wr_sel = (ir.op == 8'h07) ? wr_rd1 : (ir.op == 8'h08) ? wr_com : wr_neg;
                ctrl.wr_en = 1'b1;
              end
              8'h20, 8'h21, 8'h22, 8'h23, 8'h24, 8'h25, 8'h26: begin
                ctrl.alu_func = alu_func_t'(ir.op[3:0]);
                ctrl.rd_addr1 = ir.rb;
                ctrl.rd_addr2 = ir.rc;
                ctrl.wr_en = 1'b1;
              end
              default: state_next = st_fault;
            endcase
          end
          mode_imm: begin
            case (ir.op)
              8'h00, 8'h01, 8'h02, 8'h07, 8'h09: ctrl.pc_branch = take_branch;
              8'h0c, 8'h0d: begin  // ldis, ldiu
                ctrl.wr_sel = ir.op[0] ? wr_mdr : wr_mar;
                ctrl.wr_en = 1'b1;
              end
              default: state_next = st_fault;
            endcase
          end
          mode_regind: begin
            // effective address rb + imm into mar
            ctrl.rd_addr1 = ir.rb;
            ctrl.alu_src = src_imm;
            ctrl.rd_addr2 = ir.ra;
            case (ir.op)
              8'h00: begin  // st.l
                ctrl.mar_load_alu = 1'b1;
                ctrl.mdr_load_reg = 1'b1;
                ctrl.bus_wr_start = 1'b1;
                state_next = st_memsave;
              end
              8'h01: begin  // ld.l
                ctrl.mar_load_alu = 1'b1;
                ctrl.bus_rd_start = 1'b1;
                retstate_next = st_load_done;
                state_next = st_memload;
              end
              default: state_next = st_fault;
            endcase
          end
          default: state_next = st_fault;
        endcase
      end
      default: state_next = st_fault;  // fault holds with the bus idle
    endcase
  end

  a_no_rd_wr_together: assert property (@(posedge csi_clk) disable iff (!rsi_reset_n)
    !(ctrl.bus_rd_start && ctrl.bus_wr_start))
    else $error("read and write started together");

endmodule

/* logic/cpu_ctrl_if.sv */
`timescale 1ns/1ps
`include "bexkat_config.svh"

interface cpu_ctrl_if;
  import bexkat_pkg::*;

  alu_func_t alu_func;
  alu_src_t alu_src;
  logic [$clog2(`BEXKAT_REG_N)-1:0] rd_addr1;
  logic [$clog2(`BEXKAT_REG_N)-1:0] rd_addr2;
  logic wr_en;
  logic [$clog2(`BEXKAT_REG_N)-1:0] wr_addr;
  wr_sel_t wr_sel;          // write-back source muxed at top
  logic load_ir;
  addr_sel_t addr_sel;
  logic pc_inc;
  logic pc_branch;
  logic mar_load_alu;
  logic mdr_load_reg;
  logic mdr_load_bus;
  logic ccr_load;
  logic bus_rd_start;       // held high while a read stalls
  logic bus_wr_start;

  modport seq (output alu_func, alu_src, rd_addr1, rd_addr2, wr_en, wr_addr, wr_sel,
               load_ir, addr_sel, pc_inc, pc_branch, mar_load_alu, mdr_load_reg,
               mdr_load_bus, ccr_load, bus_rd_start, bus_wr_start);
  modport bus (input load_ir, addr_sel, pc_inc, pc_branch, mar_load_alu, mdr_load_reg,
               mdr_load_bus, ccr_load, bus_rd_start, bus_wr_start);
  modport regs (input rd_addr1, rd_addr2, wr_en, wr_addr);
  modport alu (input alu_func, alu_src);

endinterface

/* logic/bexkat_pkg.sv */
package bexkat_pkg;

  typedef enum logic [3:0] {
    st_fetch,
    st_memload,
    st_memsave,
    st_eval,
    st_load_done,
    st_store_done,
    st_fault
  } cpu_state_t;

  typedef enum logic [2:0] {
    mode_reg    = 3'd0,
    mode_regind = 3'd1,
    mode_imm    = 3'd2
  } ir_mode_t;

  typedef struct packed {
    ir_mode_t   mode;
    logic [7:0] op;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] rc;
    logic [5:0] low;
  } ir_fields_t;

  typedef logic [15:0] imm16_t;

  typedef enum logic [3:0] {
    alu_and = 4'd0,
    alu_or  = 4'd1,
    alu_add = 4'd2,
    alu_sub = 4'd3,
    alu_xor = 4'd4,
    alu_shl = 4'd5,
    alu_shr = 4'd6
  } alu_func_t;

  typedef enum logic [1:0] {src_reg, src_imm, src_one} alu_src_t;

  typedef enum logic [2:0] {wr_alu, wr_rd1, wr_com, wr_neg, wr_mar, wr_mdr} wr_sel_t;

  typedef enum logic {addr_pc, addr_mar} addr_sel_t;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } ccr_t;

endpackage

/* logic/bexkat_config.svh */
`ifndef BEXKAT_CONFIG_SVH
`define BEXKAT_CONFIG_SVH

// data and address bus width
`define BEXKAT_DATA_W 32

// first fetch address after reset
`define BEXKAT_RESET_PC 32'h0000_0000

`define BEXKAT_REG_N 32

// extra eval cycles taken by cmp
`define BEXKAT_CMP_SETTLE 2

`endif
